//--- rtl/apb_mem_master.sv
// APB master, one read or write transfer per request
`timescale 1ns/1ps

module apb_mem_master (
    input  logic               clk,
    input  logic               rst,
    input  xchg_pkg::apb_req_t req,
    output logic               bus_done,
    output logic [7:0]         rdata,
    output logic               psel,
    output logic               penable,
    output logic               pwrite,
    output logic [15:0]        paddr,
    output logic [7:0]         pwdata,
    input  logic [7:0]         prdata,
    input  logic               pready
);
    import xchg_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS
    } state_e;

    state_e   state;
    apb_req_t req_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req.op != BUS_NONE) begin
                        state <= ST_SETUP;
                    end
                end
                ST_SETUP: begin
                    state <= ST_ACCESS;
                end
                ST_ACCESS: begin
                    // back to idle drops psel for a cycle
                    if (pready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // address and data held from setup until pready
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            req_q <= req;
        end
    end

    assign psel     = (state != ST_IDLE);
    assign penable  = (state == ST_ACCESS);
    assign pwrite   = (req_q.op == BUS_WRITE);
    assign paddr    = req_q.addr;
    assign pwdata   = req_q.wdata;
    assign bus_done = (state == ST_ACCESS) && pready;
    assign rdata    = prdata;

endmodule

//--- rtl/index_regs.sv
// IX, IY, SP and the Dt/Dtex temporaries
// builds the bus request from the decoder controls
`timescale 1ns/1ps

module index_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  xchg_pkg::reg_init_t init,
    input  xchg_pkg::xix_ctl_t ctl,
    input  logic               is_y,
    input  logic               bus_done,
    input  logic [7:0]         rdata,
    output xchg_pkg::apb_req_t req,
    output logic [15:0]        ix,
    output logic [15:0]        iy,
    output logic [15:0]        sp
);
    import xchg_pkg::*;

    logic [DATA_W-1:0] dt;
    logic [DATA_W-1:0] dtex;
    logic [ADDR_W-1:0] sel_idx;
    logic              core_idle;

    // idle step decodes to no successor and no finish
    assign core_idle = (ctl.next_xpt == XPT_IDLE) && !ctl.finish;

    assign sel_idx = is_y ? iy : ix;

    // SP+1 wraps at the top of memory
    assign req.op    = ctl.bus_op;
    assign req.addr  = ctl.addr_plus1 ? sp + 16'd1 : sp;
    assign req.wdata = ctl.data_sel_dtex ? dtex : dt;

    always_ff @(posedge clk) begin
        if (rst) begin
            ix <= '0;
            iy <= '0;
            sp <= '0;
        end else if (load && core_idle) begin
            ix <= init.ix;
            iy <= init.iy;
            sp <= init.sp;
        end else if (bus_done) begin
            if (ctl.write_idx_low[0]) begin
                ix[7:0] <= rdata;
            end
            if (ctl.write_idx_low[1]) begin
                iy[7:0] <= rdata;
            end
            if (ctl.write_idx_high[0]) begin
                ix[15:8] <= rdata;
            end
            if (ctl.write_idx_high[1]) begin
                iy[15:8] <= rdata;
            end
        end
    end

    // old index bytes kept for the write-back
    always_ff @(posedge clk) begin
        if (ctl.latch_dt) begin
            dt   <= sel_idx[7:0];
            dtex <= sel_idx[15:8];
        end
    end

endmodule

//--- rtl/op_xix_decoder.sv
// step decoder for EX (SP),IX and EX (SP),IY
`timescale 1ns/1ps

module op_xix_decoder (
    input  xchg_pkg::xpt_e     xpt,
    input  logic               is_y,
    output xchg_pkg::xix_ctl_t ctl
);
    import xchg_pkg::*;

    logic [1:0] xy_sel;

    // selects the IX bit when is_y is low and the IY bit when high
    assign xy_sel = {is_y, ~is_y};

    always_comb begin
        ctl                = '0;
        ctl.bus_op         = BUS_NONE;
        ctl.next_xpt       = XPT_IDLE;

        case (xpt)
            XPT_IDLE: begin
                ctl.next_xpt = XPT_IDLE;
            end

            // old index into the temporaries
            XPT_LATCH: begin
                ctl.latch_dt = 1'b1;
                ctl.next_xpt = XPT_RD_LO;
            end

            XPT_RD_LO: begin
                ctl.bus_op        = BUS_READ;
                ctl.write_idx_low = xy_sel;
                ctl.next_xpt      = XPT_RD_HI;
            end

            // high byte comes from SP+1
            XPT_RD_HI: begin
                ctl.bus_op         = BUS_READ;
                ctl.addr_plus1     = 1'b1;
                ctl.write_idx_high = xy_sel;
                ctl.next_xpt       = XPT_WR_LO;
            end

            // old low byte back to SP
            XPT_WR_LO: begin
                ctl.bus_op        = BUS_WRITE;
                ctl.data_sel_dtex = 1'b0;
                ctl.next_xpt      = XPT_WR_HI;
            end

            XPT_WR_HI: begin
                ctl.bus_op        = BUS_WRITE;
                ctl.addr_plus1    = 1'b1;
                ctl.data_sel_dtex = 1'b1;
                ctl.next_xpt      = XPT_END;
            end

            XPT_END: begin
                ctl.finish   = 1'b1;
                ctl.next_xpt = XPT_IDLE;
            end

            default: begin
                ctl.next_xpt = XPT_IDLE;
            end
        endcase
    end

endmodule

//--- rtl/xchg_core_top.sv
// index exchange core, EX (SP),IX and EX (SP),IY over APB
`timescale 1ns/1ps

module xchg_core_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                is_y,
    input  logic                load,
    input  xchg_pkg::reg_init_t init,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output logic [15:0]         paddr,
    output logic [7:0]          pwdata,
    input  logic [7:0]          prdata,
    input  logic                pready,
    output logic                busy,
    output logic                done,
    output logic [15:0]         ix,
    output logic [15:0]         iy,
    output logic [15:0]         sp
);
    import xchg_pkg::*;

    xpt_e              xpt;
    xix_ctl_t          ctl;
    apb_req_t          req;
    logic              bus_done;
    logic [DATA_W-1:0] rdata;

    xpt_counter xpt_counter_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .bus_done (bus_done),
        .next_xpt (ctl.next_xpt),
        .xpt      (xpt),
        .busy     (busy),
        .done     (done)
    );

    op_xix_decoder op_xix_decoder_i (
        .xpt  (xpt),
        .is_y (is_y),
        .ctl  (ctl)
    );

    index_regs index_regs_i (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .init     (init),
        .ctl      (ctl),
        .is_y     (is_y),
        .bus_done (bus_done),
        .rdata    (rdata),
        .req      (req),
        .ix       (ix),
        .iy       (iy),
        .sp       (sp)
    );

    apb_mem_master apb_mem_master_i (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .bus_done (bus_done),
        .rdata    (rdata),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready)
    );

endmodule

//--- rtl/xchg_pkg.sv
// shared widths, timing step and bus op enums
// control, APB request and register init structs
package xchg_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    // step numbers follow the original XPT count
    typedef enum logic [4:0] {
        XPT_IDLE  = 5'd0,
        XPT_LATCH = 5'd3,
        XPT_RD_LO = 5'd4,
        XPT_RD_HI = 5'd7,
        XPT_WR_LO = 5'd11,
        XPT_WR_HI = 5'd14,
        XPT_END   = 5'd18
    } xpt_e;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'd0,
        BUS_READ  = 2'd1,
        BUS_WRITE = 2'd2
    } bus_op_e;

    // index write strobes carry IX in bit 0 and IY in bit 1
    typedef struct packed {
        logic       latch_dt;
        bus_op_e    bus_op;
        logic       addr_plus1;
        logic       data_sel_dtex;
        logic [1:0] write_idx_low;
        logic [1:0] write_idx_high;
        logic       finish;
        xpt_e       next_xpt;
    } xix_ctl_t;

    typedef struct packed {
        bus_op_e             op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
    } apb_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] ix;
        logic [ADDR_W-1:0] iy;
        logic [ADDR_W-1:0] sp;
    } reg_init_t;

endpackage

//--- rtl/xpt_counter.sv
// timing step register, stalls on bus steps until the transfer ends
`timescale 1ns/1ps

module xpt_counter (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic           bus_done,
    input  xchg_pkg::xpt_e next_xpt,
    output xchg_pkg::xpt_e xpt,
    output logic           busy,
    output logic           done
);
    import xchg_pkg::*;

    logic bus_step;
    logic advance;
    xpt_e xpt_nxt;

    assign bus_step = (xpt == XPT_RD_LO) || (xpt == XPT_RD_HI) ||
                      (xpt == XPT_WR_LO) || (xpt == XPT_WR_HI);

    // end step already counts as not busy so a new start can follow
    assign busy = (xpt != XPT_IDLE) && (xpt != XPT_END);

    assign advance = !bus_step || bus_done;

    always_comb begin
        if (start && !busy) begin
            xpt_nxt = XPT_LATCH;
        end else if (advance) begin
            xpt_nxt = next_xpt;
        end else begin
            xpt_nxt = xpt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            xpt  <= XPT_IDLE;
            done <= 1'b0;
        end else begin
            xpt  <= xpt_nxt;
            done <= (xpt_nxt == XPT_END);
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# builds and runs the exchange core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module tb_xchg_core \
    -Mdir "$OBJ" \
    -f xchg_core_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_xchg_core" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- tb/apb_mem_model.sv
// APB slave memory model, 64 KiB of bytes
// random wait states and a preload port for the testbench
`timescale 1ns/1ps

module apb_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [15:0] paddr,
    input  logic [7:0]  pwdata,
    output logic [7:0]  prdata,
    output logic        pready,
    input  logic        preload_en,
    input  logic [15:0] preload_addr,
    input  logic [7:0]  preload_data
);

    logic [7:0] mem [0:65535];
    logic [1:0] wait_cnt;

    // background pattern mixes every address bit
    initial begin
        logic [16:0] a;
        for (a = 17'd0; a < 17'h10000; a++) begin
            mem[a[15:0]] = a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h3c;
        end
    end

    assign pready = psel && penable && (wait_cnt == 2'd0);
    assign prdata = mem[paddr];

    always @(posedge clk) begin
        if (rst) begin
            wait_cnt <= 2'd0;
        end else begin
            // new wait count picked in the setup cycle
            if (psel && !penable) begin
                wait_cnt <= 2'($urandom % 4);
            end else if (psel && penable && wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end
            if (pready && pwrite) begin
                mem[paddr] <= pwdata;
            end
            if (preload_en) begin
                mem[preload_addr] <= preload_data;
            end
        end
    end

endmodule

//--- tb/tb_xchg_core.sv
// testbench for the index exchange core
// scoreboard for EX (SP),IX/IY and APB protocol checks
`timescale 1ns/1ps

module tb_xchg_core;
    import xchg_pkg::*;

    localparam int DONE_TIMEOUT = 200;
    localparam int RANDOM_RUNS  = 40;

    logic        clk;
    logic        rst;
    logic        start;
    logic        is_y;
    logic        load;
    reg_init_t   init;
    logic        psel, penable, pwrite, pready;
    logic [15:0] paddr;
    logic [7:0]  pwdata, prdata;
    logic        busy, done;
    logic [15:0] ix, iy, sp;
    logic        preload_en;
    logic [15:0] preload_addr;
    logic [7:0]  preload_data;

    int          errors;
    int          checks;
    int          proto_errors;
    int          done_count;
    int          xfer_total;
    int          xfer_base;
    bit          timed_out;
    logic        exp_wr [4];
    logic [15:0] exp_addr [4];
    logic [7:0]  exp_wdata [4];
    logic        prev_psel, prev_penable, prev_pready, prev_pwrite, prev_done;
    logic [15:0] prev_paddr;
    logic [7:0]  prev_pwdata;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    xchg_core_top dut_i (
        .clk (clk), .rst (rst), .start (start), .is_y (is_y), .load (load), .init (init),
        .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
        .pwdata (pwdata), .prdata (prdata), .pready (pready),
        .busy (busy), .done (done), .ix (ix), .iy (iy), .sp (sp)
    );

    apb_mem_model mem_i (
        .clk (clk), .rst (rst), .psel (psel), .penable (penable), .pwrite (pwrite),
        .paddr (paddr), .pwdata (pwdata), .prdata (prdata), .pready (pready),
        .preload_en (preload_en), .preload_addr (preload_addr), .preload_data (preload_data)
    );

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic protocol_fail(input string what);
        proto_errors++;
        $display("protocol error at %0t ns: %s", $time, what);
    endtask

    task automatic bus_value_fail(input string name, input logic [15:0] got,
                                  input logic [15:0] exp);
        proto_errors++;
        $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
    endtask

    // APB and handshake monitor on the falling edge
    always @(negedge clk) begin
        int         k;
        logic [1:0] slot;
        if (penable && !prev_penable) begin
            assert (prev_psel) else protocol_fail("penable rose without a setup cycle");
        end
        assert (!penable || psel) else protocol_fail("penable high while psel low");
        if (prev_psel && !prev_pready && psel) begin
            assert (paddr == prev_paddr && pwrite == prev_pwrite && pwdata == prev_pwdata)
                else protocol_fail("paddr, pwrite or pwdata changed before pready");
        end
        if (prev_pready) begin
            assert (!psel) else protocol_fail("psel stayed high after a transfer");
        end
        if (psel && penable && pready) begin
            k = xfer_total - xfer_base;
            slot = k[1:0];
            if (k > 3) begin
                protocol_fail("more than four bus transfers in one instruction");
            end else begin
                assert (pwrite == exp_wr[slot])
                    else bus_value_fail("pwrite", 16'(pwrite), 16'(exp_wr[slot]));
                assert (paddr == exp_addr[slot])
                    else bus_value_fail("paddr", paddr, exp_addr[slot]);
                if (exp_wr[slot]) begin
                    assert (pwdata == exp_wdata[slot])
                        else bus_value_fail("pwdata", 16'(pwdata), 16'(exp_wdata[slot]));
                end
            end
            xfer_total++;
        end
        if (done) begin
            done_count++;
        end
        assert (!(done && busy)) else protocol_fail("busy still high with done");
        if (prev_done) begin
            assert (!done && !busy) else protocol_fail("done longer than one cycle or busy after it");
        end
        prev_psel    = psel;
        prev_penable = penable;
        prev_pready  = pready;
        prev_pwrite  = pwrite;
        prev_paddr   = paddr;
        prev_pwdata  = pwdata;
        prev_done    = done;
    end

    task automatic preload(input logic [15:0] a, input logic [7:0] d);
        @(negedge clk);
        preload_en   = 1'b1;
        preload_addr = a;
        preload_data = d;
    endtask

    task automatic run_exchange(input logic sel_y, input logic [15:0] ix0,
                                input logic [15:0] iy0, input logic [15:0] sp0,
                                input logic [7:0] lo, input logic [7:0] hi,
                                input bit poke_start);
        logic [15:0] sp1;
        logic [15:0] old_idx;
        int          base_done;
        int          cycles;
        sp1 = sp0 + 16'd1;
        old_idx = sel_y ? iy0 : ix0;
        if (timed_out) begin
            return;
        end
        preload(sp0, lo);
        preload(sp1, hi);
        @(negedge clk);
        preload_en = 1'b0;
        init = '{ix: ix0, iy: iy0, sp: sp0};
        load = 1'b1;
        @(negedge clk);
        load = 1'b0;
        exp_wr    = '{1'b0, 1'b0, 1'b1, 1'b1};
        exp_addr  = '{sp0, sp1, sp0, sp1};
        exp_wdata = '{8'h00, 8'h00, old_idx[7:0], old_idx[15:8]};
        xfer_base = xfer_total;
        base_done = done_count;
        is_y  = sel_y;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_val("busy after start", 16'(busy), 16'h1);
        // extra start pulses while the core is busy
        if (poke_start) begin
            repeat (2) @(negedge clk);
            repeat (3) begin
                check_val("busy", 16'(busy), 16'h1);
                start = 1'b1;
                @(negedge clk);
            end
            start = 1'b0;
        end
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: no done within %0d cycles after start", DONE_TIMEOUT);
            return;
        end
        repeat (3) @(negedge clk);
        check_val("done pulses", 16'(done_count - base_done), 16'd1);
        check_val("bus transfers", 16'(xfer_total - xfer_base), 16'd4);
        check_val(sel_y ? "iy" : "ix", sel_y ? iy : ix, {hi, lo});
        check_val(sel_y ? "ix" : "iy", sel_y ? ix : iy, sel_y ? ix0 : iy0);
        check_val("sp", sp, sp0);
        check_val("mem[sp]", 16'(mem_i.mem[sp0]), 16'(old_idx[7:0]));
        check_val("mem[sp+1]", 16'(mem_i.mem[sp1]), 16'(old_idx[15:8]));
    endtask

    task automatic end_run();
        $display("checks %0d, value errors %0d, protocol errors %0d",
                 checks, errors, proto_errors);
        if (errors == 0 && proto_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(32'hdf14));
        errors       = 0;
        checks       = 0;
        timed_out    = 1'b0;
        xfer_base    = 0;
        rst          = 1'b1;
        start        = 1'b0;
        is_y         = 1'b0;
        load         = 1'b0;
        init         = '0;
        preload_en   = 1'b0;
        preload_addr = 16'h0000;
        preload_data = 8'h00;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_val("busy", 16'(busy), 16'h0);
        check_val("done", 16'(done), 16'h0);
        check_val("psel", 16'(psel), 16'h0);
        check_val("penable", 16'(penable), 16'h0);

        run_exchange(1'b0, 16'h1234, 16'h5678, 16'h8000, 8'hcd, 8'hab, 1'b0);
        run_exchange(1'b1, 16'h9abc, 16'hdef0, 16'h4002, 8'h11, 8'h22, 1'b0);
        // stack pointer at the top wraps SP+1 to 0
        run_exchange(1'b0, 16'hbeef, 16'hcafe, 16'hffff, 8'h5a, 8'ha5, 1'b0);
        run_exchange(1'b1, 16'h0f0f, 16'hf0f0, 16'hffff, 8'h3c, 8'hc3, 1'b0);
        run_exchange(1'b0, 16'h2468, 16'h1357, 16'h1000, 8'h77, 8'h88, 1'b1);
        repeat (RANDOM_RUNS) begin
            run_exchange(1'($urandom), 16'($urandom), 16'($urandom), 16'($urandom),
                         8'($urandom), 8'($urandom), 1'($urandom));
        end
        end_run();
    end

endmodule

//--- xchg_core_top.f
rtl/xchg_pkg.sv
rtl/xpt_counter.sv
rtl/op_xix_decoder.sv
rtl/index_regs.sv
rtl/apb_mem_master.sv
rtl/xchg_core_top.sv
tb/apb_mem_model.sv
tb/tb_xchg_core.sv
